/* source/merge_data_pkg.sv */
package merge_data_pkg;

    // Data path sizing
    localparam int DATA_W  = 32;  // Lane word and output word
    localparam int DELAY_W = 8;   // Start delay before a sweep
    localparam int LANES   = 16;
    localparam int LANE_W  = 4;   // Index into LANES

    // Merge sequencing
    typedef enum logic [1:0] {
        MRG_IDLE,
        MRG_WAIT,   // Counting down the start delay
        MRG_SWEEP   // One lane per cycle
    } merge_state_t;

endpackage

/* source/merge_cfg_pkg.sv */
package merge_cfg_pkg;

    localparam int WB_ADR_W = 5;  // Word addresses

    // Register map
    localparam logic [WB_ADR_W-1:0] ADR_LANE0  = WB_ADR_W'(0);   // Lanes at 0 to 15
    localparam logic [WB_ADR_W-1:0] ADR_DELAY  = WB_ADR_W'(16);
    localparam logic [WB_ADR_W-1:0] ADR_CTRL   = WB_ADR_W'(17);  // Write only
    localparam logic [WB_ADR_W-1:0] ADR_STATUS = WB_ADR_W'(18);  // Bit 0 is busy

    // Opcodes written to ADR_CTRL
    typedef enum logic [1:0] {
        CMD_NOP   = 2'd0,
        CMD_RUN   = 2'd1,  // Start a sweep
        CMD_CLEAR = 2'd2   // Zero all lane words
    } merge_cmd_t;

endpackage

/* source/lane_bus_if.sv */
`timescale 1ns/10ps

interface lane_bus_if;
    import merge_data_pkg::*;

    logic [LANES-1:0][DATA_W-1:0] lanes;  // Skewed lane words
    logic                         run;    // Sweep start pulse
    logic [DELAY_W-1:0]           delay;

    // Skew stage side
    modport src (
        output lanes,
        output run,
        output delay
    );

    // Merge side
    modport snk (
        input lanes,
        input run,
        input delay
    );

endinterface

/* source/wb_lane_regs.sv */
`timescale 1ns/10ps

module wb_lane_regs (
    input  logic                                                    clk,
    input  logic                                                    rst,
    input  logic                                                    wb_cyc,
    input  logic                                                    wb_stb,
    input  logic                                                    wb_we,
    input  logic [merge_cfg_pkg::WB_ADR_W-1:0]                      wb_adr,
    input  logic [merge_data_pkg::DATA_W-1:0]                       wb_dat_w,
    output logic [merge_data_pkg::DATA_W-1:0]                       wb_dat_r,
    output logic                                                    wb_ack,
    output logic                                                    run,
    output logic [merge_data_pkg::LANES*merge_data_pkg::DATA_W-1:0] lane_words,
    output logic [merge_data_pkg::DELAY_W-1:0]                      delay_value,
    input  logic                                                    busy
);
    import merge_data_pkg::*;
    import merge_cfg_pkg::*;

    logic [LANES-1:0][DATA_W-1:0] lanes_q;
    logic [DELAY_W-1:0]           delay_q;
    logic [DATA_W-1:0]            rd_data;
    logic [LANE_W-1:0]            lane_idx;
    logic                         lane_hit;
    logic                         access;
    logic                         cmd_hit;
    logic                         run_cmd;
    logic                         clear_cmd;
    merge_cmd_t                   cmd;

    assign access   = wb_cyc && wb_stb && !wb_ack;  // First cycle of a transfer
    assign lane_hit = (wb_adr < WB_ADR_W'(ADR_LANE0 + LANES));
    assign lane_idx = LANE_W'(wb_adr - ADR_LANE0);
    assign cmd      = merge_cmd_t'(wb_dat_w[$bits(merge_cmd_t)-1:0]);
    assign cmd_hit  = wb_ack && wb_we && (wb_adr == ADR_CTRL);  // Master holds until ack

    assign lane_words  = lanes_q;
    assign delay_value = delay_q;

    always_comb begin
        run_cmd   = 1'b0;
        clear_cmd = 1'b0;
        case (cmd)
            CMD_RUN:   run_cmd   = cmd_hit;
            CMD_CLEAR: clear_cmd = cmd_hit;
            CMD_NOP:   ;
            default:   ;
        endcase
    end

    always_comb begin
        rd_data = '0;  // Unmapped and control reads
        if (lane_hit) begin
            rd_data = lanes_q[lane_idx];
        end else if (wb_adr == ADR_DELAY) begin
            rd_data = DATA_W'(delay_q);
        end else if (wb_adr == ADR_STATUS) begin
            rd_data = DATA_W'(busy);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_ack  <= 1'b0;
            run     <= 1'b0;
            delay_q <= '0;
        end else begin
            wb_ack <= access;
            run    <= run_cmd;  // Cycle after the ack
            if (access && wb_we && (wb_adr == ADR_DELAY)) begin
                delay_q <= wb_dat_w[DELAY_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access && !wb_we) begin
            wb_dat_r <= rd_data;
        end
        if (clear_cmd) begin
            lanes_q <= '0;
        end else if (access && wb_we && lane_hit) begin
            lanes_q[lane_idx] <= wb_dat_w;
        end
    end

    // Ack lasts one cycle even when the master starts a new transfer right away
    ack_pulse_a: assert property (@(posedge clk) disable iff (rst)
        wb_ack |=> !wb_ack);

    ack_in_cycle_a: assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> (wb_cyc && wb_stb));

endmodule

/* source/lane_skew.sv */
`timescale 1ns/10ps

module lane_skew (
    input  logic                                                    clk,
    input  logic                                                    rst,
    input  logic                                                    run,
    input  logic [merge_data_pkg::LANES*merge_data_pkg::DATA_W-1:0] lane_words,
    input  logic [merge_data_pkg::DELAY_W-1:0]                      delay_value,
    lane_bus_if.src                                                 bus
);
    import merge_data_pkg::*;

    logic [LANES-1:0][DATA_W-1:0] words_in;
    logic [LANES-1:1][DATA_W-1:0] cap_q;    // Lane 0 loads straight from the bank
    logic [LANES-2:0]             rel_q;    // Bit k-1 releases lane k
    logic [LANES-1:0][DATA_W-1:0] lanes_q;

    assign words_in = lane_words;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rel_q <= '0;
        end else if (run) begin
            rel_q <= {{(LANES-2){1'b0}}, 1'b1};  // Restart the stagger
        end else begin
            rel_q <= rel_q << 1;
        end
    end

    always_ff @(posedge clk) begin
        if (run) begin
            cap_q      <= words_in[LANES-1:1];
            lanes_q[0] <= words_in[0];
        end
        for (int k = 1; k < LANES; k++) begin
            if (rel_q[k-1]) begin
                lanes_q[k] <= cap_q[k];  // k cycles after lane 0
            end
        end
    end

    assign bus.lanes = lanes_q;
    assign bus.run   = run;
    assign bus.delay = delay_value;

    // Only one lane opens per cycle
    rel_onehot_a: assert property (@(posedge clk) disable iff (rst)
        $onehot0(rel_q));

endmodule

/* source/merge_unit.sv */
`timescale 1ns/10ps

module merge_unit (
    input  logic                              clk,
    input  logic                              rst,
    lane_bus_if.snk                           bus,
    output logic [merge_data_pkg::DATA_W-1:0] merge_out,
    output logic                              merge_valid,
    output logic                              busy
);
    import merge_data_pkg::*;

    merge_state_t       state;
    logic [DELAY_W-1:0] delay_cnt;
    logic [LANE_W-1:0]  lane_cnt;
    logic               last_lane;

    assign last_lane = (lane_cnt == LANE_W'(LANES - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= MRG_IDLE;
            delay_cnt <= '0;
            lane_cnt  <= '0;
        end else if (bus.run) begin
            delay_cnt <= bus.delay;  // Restarts an active sweep too
            lane_cnt  <= '0;
            state     <= (bus.delay == '0) ? MRG_SWEEP : MRG_WAIT;
        end else begin
            case (state)
                MRG_WAIT: begin
                    delay_cnt <= delay_cnt - 1'b1;
                    if (delay_cnt == DELAY_W'(1)) begin
                        state <= MRG_SWEEP;
                    end
                end
                MRG_SWEEP: begin
                    lane_cnt <= lane_cnt + 1'b1;  // Wraps on the last lane
                    if (last_lane) begin
                        state <= MRG_IDLE;
                    end
                end
                default: state <= MRG_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            merge_out   <= '0;
            merge_valid <= 1'b0;
        end else begin
            merge_valid <= (state == MRG_SWEEP);
            merge_out   <= (state == MRG_SWEEP) ? bus.lanes[lane_cnt] : '0;
        end
    end

    // Covers the run cycle and the final registered word
    assign busy = bus.run || (state != MRG_IDLE) || merge_valid;

    // Valid words only once the start delay has run out
    valid_in_sweep_a: assert property (@(posedge clk) disable iff (rst)
        merge_valid |-> $past((state == MRG_SWEEP) && (delay_cnt == '0)));

    // Counter returns to zero only at the end of a sweep or on a run
    wrap_at_end_a: assert property (@(posedge clk) disable iff (rst)
        ($changed(lane_cnt) && (lane_cnt == '0) && !$past(bus.run))
            |-> $past((state == MRG_SWEEP) && last_lane));

endmodule

/* source/merge_top.sv */
`timescale 1ns/10ps

module merge_top (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              wb_cyc,
    input  logic                              wb_stb,
    input  logic                              wb_we,
    input  logic [merge_cfg_pkg::WB_ADR_W-1:0] wb_adr,
    input  logic [merge_data_pkg::DATA_W-1:0] wb_dat_w,
    output logic [merge_data_pkg::DATA_W-1:0] wb_dat_r,
    output logic                              wb_ack,
    output logic [merge_data_pkg::DATA_W-1:0] merge_out,
    output logic                              merge_valid
);
    import merge_data_pkg::*;

    logic [LANES*DATA_W-1:0] lane_words;
    logic [DELAY_W-1:0]      delay_value;
    logic                    run;
    logic                    busy;

    lane_bus_if lane_bus ();

    wb_lane_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .run         (run),
        .lane_words  (lane_words),
        .delay_value (delay_value),
        .busy        (busy)
    );

    lane_skew u_skew (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .lane_words  (lane_words),
        .delay_value (delay_value),
        .bus         (lane_bus.src)
    );

    merge_unit u_merge (
        .clk         (clk),
        .rst         (rst),
        .bus         (lane_bus.snk),
        .merge_out   (merge_out),
        .merge_valid (merge_valid),
        .busy        (busy)
    );

endmodule

/* tb/merge_tb.sv */
`timescale 1ns/10ps

module merge_tb;
    import merge_data_pkg::*;
    import merge_cfg_pkg::*;

    localparam int PERIOD     = 20;
    localparam int NUM_SWEEPS = 20;
    localparam int NUM_TESTS  = NUM_SWEEPS + 6;  // Readback, restart, busy, clear
    localparam int BUS_CYCLES = 64;              // Lane and delay writes of one test
    localparam int MAX_DELAY  = 255;

    logic                clk;
    logic                rst;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    logic [WB_ADR_W-1:0] wb_adr;
    logic [DATA_W-1:0]   wb_dat_w;
    logic [DATA_W-1:0]   wb_dat_r;
    logic                wb_ack;
    logic [DATA_W-1:0]   merge_out;
    logic                merge_valid;

    integer             seed;
    int                 value_errors;
    int                 other_errors;
    int                 cycle;
    int                 last_ack_cycle;
    logic [DATA_W-1:0]  model_lanes [LANES];
    logic [DELAY_W-1:0] model_delay;
    logic [DATA_W-1:0]  got_words [$];
    int                 got_cycles [$];
    int                 sweep_delay [NUM_SWEEPS];
    int                 sweep_lat [NUM_SWEEPS];

    merge_top dut0 (
        .clk         (clk),
        .rst         (rst),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .merge_out   (merge_out),
        .merge_valid (merge_valid)
    );

    initial clk = 1'b0;
    always #(PERIOD/2) clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    always @(negedge clk) begin
        if (!rst && merge_valid) begin
            got_words.push_back(merge_out);
            got_cycles.push_back(cycle);  // Kept for gap and latency checks
        end
    end

    task automatic compare_value(input string name, input logic [DATA_W-1:0] actual,
                                 input logic [DATA_W-1:0] expected);
        if (actual !== expected) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
            value_errors++;
        end
    endtask

    task automatic bus_transfer(input logic we, input logic [WB_ADR_W-1:0] adr,
                                input logic [DATA_W-1:0] wdata,
                                output logic [DATA_W-1:0] rdata);
        int waited;
        waited = 0;
        rdata = '0;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        do begin
            @(negedge clk);
            waited++;
        end while (!wb_ack && waited < 8);
        if (wb_ack) begin
            rdata = wb_dat_r;
            last_ack_cycle = cycle;
        end else begin
            $display("no Wishbone ack for the access to address %0d", adr);
            other_errors++;
        end
        @(negedge clk);  // Hold through the edge that takes the ack
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [WB_ADR_W-1:0] adr, input logic [DATA_W-1:0] data);
        logic [DATA_W-1:0] unused;
        bus_transfer(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [WB_ADR_W-1:0] adr, output logic [DATA_W-1:0] data);
        bus_transfer(1'b0, adr, '0, data);
    endtask

    task automatic load_random_lanes();
        for (int k = 0; k < LANES; k++) begin
            model_lanes[k] = $random(seed);
            wb_write(ADR_LANE0 + WB_ADR_W'(k), model_lanes[k]);
        end
    endtask

    task automatic set_delay(input logic [DELAY_W-1:0] d);
        model_delay = d;
        wb_write(ADR_DELAY, DATA_W'(d));
    endtask

    task automatic start_run();
        wb_write(ADR_CTRL, DATA_W'(CMD_RUN));
    endtask

    // Returns once sixteen words are in and the stream has gone quiet
    task automatic wait_sweep_end(input int limit);
        int waited;
        int idle;
        waited = 0;
        idle = 0;
        while ((got_words.size() < LANES || idle < 8) && waited < limit) begin
            @(negedge clk);
            waited++;
            idle = merge_valid ? 0 : idle + 1;
        end
        if (waited >= limit) begin
            $display("sweep did not finish within %0d cycles", limit);
            other_errors++;
        end
    endtask

    // The last sixteen words must be lanes 0 to 15 back to back
    task automatic check_sweep_words();
        int base;
        if (got_words.size() < LANES) begin
            $display("only %0d valid words arrived for a sweep", got_words.size());
            other_errors++;
        end else begin
            base = got_words.size() - LANES;
            for (int i = 0; i < LANES; i++) begin
                compare_value($sformatf("merge_out lane %0d", i), got_words[base+i],
                              model_lanes[i]);
                if (i > 0 && got_cycles[base+i] != got_cycles[base+i-1] + 1) begin
                    $display("sweep word %0d did not follow the previous word directly", i);
                    other_errors++;
                end
            end
        end
    endtask

    initial begin
        int d;
        logic [DATA_W-1:0] rd;
        seed = 32'he535b155;
        value_errors = 0;
        other_errors = 0;
        cycle = 0;
        last_ack_cycle = 0;
        rst = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        compare_value("merge_valid", DATA_W'(merge_valid), '0);
        compare_value("merge_out", merge_out, '0);
        compare_value("wb_ack", DATA_W'(wb_ack), '0);
        rst = 1'b0;

        repeat (2) begin
            load_random_lanes();
            set_delay(DELAY_W'($random(seed)));
            for (int k = 0; k < LANES; k++) begin
                wb_read(ADR_LANE0 + WB_ADR_W'(k), rd);
                compare_value($sformatf("wb_dat_r lane %0d", k), rd, model_lanes[k]);
            end
            wb_read(ADR_DELAY, rd);
            compare_value("wb_dat_r delay", rd, DATA_W'(model_delay));
        end
        wb_write(WB_ADR_W'(25), 32'hdeadbeef);  // Unmapped, acked and dropped
        wb_read(WB_ADR_W'(19), rd);
        compare_value("wb_dat_r unmapped", rd, '0);
        wb_read(WB_ADR_W'(25), rd);
        compare_value("wb_dat_r unmapped", rd, '0);

        for (int t = 0; t < NUM_SWEEPS; t++) begin
            load_random_lanes();
            d = (t == 0) ? 0 : ($random(seed) & 63);
            set_delay(DELAY_W'(d));
            got_words.delete();
            got_cycles.delete();
            start_run();
            wait_sweep_end(d + 64);
            compare_value("valid word count", DATA_W'(got_words.size()), DATA_W'(LANES));
            check_sweep_words();
            sweep_delay[t] = d;
            sweep_lat[t] = (got_words.size() > 0) ? got_cycles[0] - last_ack_cycle : 0;
        end
        for (int i = 0; i < NUM_SWEEPS; i++) begin
            for (int j = 0; j < NUM_SWEEPS; j++) begin
                if (sweep_delay[i] < sweep_delay[j] && sweep_lat[j] < sweep_lat[i]) begin
                    $display("delay %0d gave its first word before delay %0d did",
                             sweep_delay[j], sweep_delay[i]);
                    other_errors++;
                end
            end
        end

        // Long wait, new words loaded meanwhile, then a restart mid-sweep
        load_random_lanes();
        set_delay(8'd200);
        got_words.delete();
        got_cycles.delete();
        start_run();
        wb_read(ADR_STATUS, rd);
        compare_value("status busy", rd, 32'd1);
        load_random_lanes();
        set_delay(8'd3);
        d = 0;
        while (!merge_valid && d < 300) begin
            @(negedge clk);
            d++;
        end
        if (!merge_valid) begin
            $display("no sweep started after the long delay");
            other_errors++;
        end
        repeat (4) @(negedge clk);
        start_run();
        wait_sweep_end(64);
        check_sweep_words();
        wb_read(ADR_STATUS, rd);
        compare_value("status busy", rd, '0);

        wb_write(ADR_CTRL, DATA_W'(CMD_CLEAR));
        for (int k = 0; k < LANES; k++) begin
            model_lanes[k] = '0;
        end
        set_delay('0);
        got_words.delete();
        got_cycles.delete();
        start_run();
        wait_sweep_end(64);
        compare_value("valid word count", DATA_W'(got_words.size()), DATA_W'(LANES));
        check_sweep_words();

        $display("checks done: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        #(NUM_TESTS * (LANES + MAX_DELAY + BUS_CYCLES) * 4 * PERIOD);
        $display("watchdog timeout, the tests did not finish in time");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* merge_sys.f */
source/merge_data_pkg.sv
source/merge_cfg_pkg.sv
source/lane_bus_if.sv
source/wb_lane_regs.sv
source/lane_skew.sv
source/merge_unit.sv
source/merge_top.sv
tb/merge_tb.sv
